// ==== icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                                clk,
    input  logic                                i_rst_n,

    input  logic                                i_fetch_en,
    input  icache_pkg::ic_addr_t                i_fetch_addr,
    input  logic                                i_busy,

    input  logic                                i_rd_valid,
    input  logic [icache_pkg::TAG_WIDTH-1:0]    i_rd_tag,
    input  logic [icache_pkg::LINE_WIDTH-1:0]   i_rd_line,
    output logic                                o_rd_en,
    output logic [icache_pkg::INDEX_WIDTH-1:0]  o_rd_index,

    output logic                                o_fetch_valid,
    output logic                                o_fetch_hit,
    output logic [icache_pkg::INSN_WIDTH-1:0]   o_fetch_insn,
    output logic                                o_miss,
    output icache_pkg::ic_addr_t                o_miss_addr
);

    logic                              it_accept;
    logic                              it_valid_r;
    icache_pkg::ic_addr_t              it_addr_r;
    logic                              ir_hit;
    logic [icache_pkg::INSN_WIDTH-1:0] ir_insn;

    // IT stage drops fetches while a refill owns the arrays
    assign it_accept  = i_fetch_en & ~i_busy;
    assign o_rd_en    = it_accept;
    assign o_rd_index = i_fetch_addr.f.index;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            it_valid_r <= 1'b0;
        end else begin
            it_valid_r <= it_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (it_accept) begin
            it_addr_r <= i_fetch_addr;
        end
    end

    // IR stage compares the tag against the registered array read
    assign ir_hit = i_rd_valid & (i_rd_tag == it_addr_r.f.tag);

    always_comb begin
        ir_insn = '0;
        for (int i = 0; i < icache_pkg::LINE_WORDS; i++) begin
            if (icache_pkg::WORD_SEL_WIDTH'(i) == it_addr_r.f.word) begin
                ir_insn = i_rd_line[i*icache_pkg::INSN_WIDTH +: icache_pkg::INSN_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_fetch_valid <= 1'b0;
            o_fetch_hit   <= 1'b0;
            o_miss        <= 1'b0;
        end else begin
            o_fetch_valid <= it_valid_r;
            o_fetch_hit   <= it_valid_r & ir_hit;
            o_miss        <= it_valid_r & ~ir_hit;
        end
    end

    // Selected word and miss address follow the IR stage
    always_ff @(posedge clk) begin
        o_fetch_insn <= ir_insn;
        o_miss_addr  <= it_addr_r;
    end

endmodule

// ==== icache_checker.sv ====
`timescale 1ns/1ps

module icache_checker (
    input logic                 clk,
    input logic                 i_rst_n,
    input logic                 i_fetch_en,
    input logic                 o_busy,
    input logic                 o_fetch_valid,
    input logic                 o_fetch_hit,
    input logic                 o_mem_req,
    input icache_pkg::ic_addr_t o_mem_addr
);

    a_hit_has_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_fetch_hit |-> o_fetch_valid)
        else $error("fetch hit without fetch valid");

    // Accepted fetch gives its result exactly two cycles later
    a_fetch_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_fetch_en && !o_busy) |-> ##2 o_fetch_valid)
        else $error("accepted fetch gave no result two cycles later");

    a_req_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_mem_req |=> !o_mem_req)
        else $error("memory request longer than one cycle");

    a_req_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_mem_req |-> (o_mem_addr.raw[3:0] == 4'h0))
        else $error("memory request address not line aligned");

    a_idle_after_reset: assert property (@(posedge clk)
        $rose(i_rst_n) |-> !o_busy)
        else $error("busy high right after reset");

endmodule

bind icache_top icache_checker icache_checker_inst (
    .clk(clk), .i_rst_n(i_rst_n), .i_fetch_en(i_fetch_en), .o_busy(o_busy),
    .o_fetch_valid(o_fetch_valid), .o_fetch_hit(o_fetch_hit),
    .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr)
);

// ==== icache_fill_buffer.sv ====
`timescale 1ns/1ps

module icache_fill_buffer (
    input  logic                                clk,
    input  logic                                i_rst_n,

    input  logic                                i_start,
    input  logic                                i_mem_valid,
    input  logic [icache_pkg::INSN_WIDTH-1:0]   i_mem_data,

    output logic                                o_line_done,
    output logic [icache_pkg::LINE_WIDTH-1:0]   o_line_data
);

    logic [icache_pkg::WORD_SEL_WIDTH-1:0] beat_cnt_r;
    logic                                  last_beat;

    assign last_beat = i_mem_valid &&
                       (beat_cnt_r == icache_pkg::WORD_SEL_WIDTH'(icache_pkg::LINE_WORDS - 1));

    // Beat counter restarted by each new line request
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            beat_cnt_r <= '0;
        end else if (i_start) begin
            beat_cnt_r <= '0;
        end else if (i_mem_valid) begin
            beat_cnt_r <= beat_cnt_r + 1'b1;
        end
    end

    // Done pulse lands the cycle after the final word
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_line_done <= 1'b0;
        end else begin
            o_line_done <= last_beat & ~i_start;
        end
    end

    // Word 0 arrives first, so the count is the slot
    always_ff @(posedge clk) begin
        if (i_mem_valid && !i_start) begin
            for (int i = 0; i < icache_pkg::LINE_WORDS; i++) begin
                if (icache_pkg::WORD_SEL_WIDTH'(i) == beat_cnt_r) begin
                    o_line_data[i*icache_pkg::INSN_WIDTH +: icache_pkg::INSN_WIDTH] <=
                        i_mem_data;
                end
            end
        end
    end

endmodule

// ==== icache_pkg.sv ====
package icache_pkg;

    // Fetch side widths
    localparam int ADDR_WIDTH = 32;
    localparam int INSN_WIDTH = 32;

    // Line geometry
    localparam int LINE_WORDS     = 4;
    localparam int LINE_WIDTH     = LINE_WORDS * INSN_WIDTH;
    localparam int OFFSET_WIDTH   = 4;
    localparam int WORD_SEL_WIDTH = 2;
    localparam int BYTE_SEL_WIDTH = OFFSET_WIDTH - WORD_SEL_WIDTH;

    // 16 direct-mapped lines
    localparam int INDEX_WIDTH = 4;
    localparam int NUM_LINES   = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // Address split as seen by the pipeline and the refill path
    typedef struct packed {
        logic [TAG_WIDTH-1:0]      tag;
        logic [INDEX_WIDTH-1:0]    index;
        logic [WORD_SEL_WIDTH-1:0] word;
        logic [BYTE_SEL_WIDTH-1:0] byte_sel;
    } ic_addr_fields_t;

    // One address word read either raw or by field
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        ic_addr_fields_t       f;
    } ic_addr_t;

endpackage

// ==== icache_ram.sv ====
`timescale 1ns/1ps

module icache_ram (
    input  logic                                clk,
    input  logic                                i_rst_n,

    input  logic                                i_rd_en,
    input  logic [icache_pkg::INDEX_WIDTH-1:0]  i_rd_index,

    input  logic                                i_wr_en,
    input  logic [icache_pkg::INDEX_WIDTH-1:0]  i_wr_index,
    input  logic [icache_pkg::TAG_WIDTH-1:0]    i_wr_tag,
    input  logic [icache_pkg::LINE_WIDTH-1:0]   i_wr_line,

    input  logic                                i_clr_valid,

    output logic                                o_rd_valid,
    output logic [icache_pkg::TAG_WIDTH-1:0]    o_rd_tag,
    output logic [icache_pkg::LINE_WIDTH-1:0]   o_rd_line
);

    logic [icache_pkg::TAG_WIDTH-1:0]  tag_mem  [icache_pkg::NUM_LINES];
    logic [icache_pkg::LINE_WIDTH-1:0] line_mem [icache_pkg::NUM_LINES];
    logic [icache_pkg::NUM_LINES-1:0]  valid_r;

    // Valid bits cleared by reset or invalidate and set by a line write
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_r <= '0;
        end else if (i_clr_valid) begin
            valid_r <= '0;
        end else if (i_wr_en) begin
            valid_r[i_wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
    end

    // Registered read with the result one cycle after i_rd_en
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_rd_valid <= 1'b0;
        end else if (i_rd_en) begin
            o_rd_valid <= valid_r[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_tag  <= tag_mem[i_rd_index];
            o_rd_line <= line_mem[i_rd_index];
        end
    end

endmodule

// ==== icache_refill_fsm.sv ====
`timescale 1ns/1ps

module icache_refill_fsm (
    input  logic                                clk,
    input  logic                                i_rst_n,

    input  logic                                i_miss,
    input  icache_pkg::ic_addr_t                i_miss_addr,
    input  logic                                i_line_done,
    input  logic                                i_inval,

    output logic                                o_busy,
    output logic                                o_mem_req,
    output icache_pkg::ic_addr_t                o_mem_addr,
    output logic                                o_fill_en,
    output logic [icache_pkg::INDEX_WIDTH-1:0]  o_fill_index,
    output logic [icache_pkg::TAG_WIDTH-1:0]    o_fill_tag,
    output logic                                o_clr_valid
);

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] WAIT  = 2'd1;
    localparam logic [1:0] WRITE = 2'd2;

    logic [1:0]                          state_r;
    logic                                start_refill;
    logic [icache_pkg::TAG_WIDTH-1:0]    tag_r;
    logic [icache_pkg::INDEX_WIDTH-1:0]  index_r;

    // Misses seen outside IDLE are left to the requester to retry
    assign start_refill = (state_r == IDLE) & i_miss;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_r   <= IDLE;
            o_mem_req <= 1'b0;
        end else begin
            o_mem_req <= start_refill;
            case (state_r)
                IDLE:    if (i_miss) state_r <= WAIT;
                WAIT:    if (i_line_done) state_r <= WRITE;
                WRITE:   state_r <= IDLE;
                default: state_r <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_refill) begin
            tag_r   <= i_miss_addr.f.tag;
            index_r <= i_miss_addr.f.index;
        end
    end

    // Line-aligned request address
    always_comb begin
        o_mem_addr.raw     = '0;
        o_mem_addr.f.tag   = tag_r;
        o_mem_addr.f.index = index_r;
    end

    assign o_busy       = (state_r != IDLE);
    assign o_fill_en    = (state_r == WRITE);
    assign o_fill_index = index_r;
    assign o_fill_tag   = tag_r;

    // Invalidate only takes effect with no refill under way
    assign o_clr_valid  = i_inval & (state_r == IDLE);

endmodule

// ==== icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

    logic                                clk;
    logic                                i_rst_n;
    logic                                i_fetch_en;
    icache_pkg::ic_addr_t                i_fetch_addr;
    logic                                i_inval;
    logic                                i_mem_valid;
    logic [icache_pkg::INSN_WIDTH-1:0]   i_mem_data;
    logic                                o_fetch_valid;
    logic                                o_fetch_hit;
    logic [icache_pkg::INSN_WIDTH-1:0]   o_fetch_insn;
    logic                                o_busy;
    logic                                o_mem_req;
    icache_pkg::ic_addr_t                o_mem_addr;

    integer               seed = 32'h7ea8;
    int                   err_count;
    int                   tests_passed;
    int                   tests_failed;
    int                   req_count;
    icache_pkg::ic_addr_t last_req_addr;

    tb_clk_gen tb_clk_gen_inst (.clk(clk), .o_rst_n(i_rst_n));

    icache_top icache_top_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_fetch_en(i_fetch_en), .i_fetch_addr(i_fetch_addr), .i_inval(i_inval),
        .i_mem_valid(i_mem_valid), .i_mem_data(i_mem_data),
        .o_fetch_valid(o_fetch_valid), .o_fetch_hit(o_fetch_hit),
        .o_fetch_insn(o_fetch_insn), .o_busy(o_busy),
        .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr)
    );

    // Each memory word is its byte address XOR a constant
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hC0DE_0000;
    endfunction

    // Memory model answering each request with four beats and random gaps
    initial begin
        int gap;
        forever begin
            @(negedge clk);
            if (o_mem_req) begin
                req_count++;
                last_req_addr = o_mem_addr;
                for (int w = 0; w < icache_pkg::LINE_WORDS; w++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) begin
                        @(posedge clk);
                        i_mem_valid <= 1'b0;
                    end
                    @(posedge clk);
                    i_mem_valid <= 1'b1;
                    i_mem_data  <= mem_word(last_req_addr.raw + 32'(w * 4));
                end
                @(posedge clk);
                i_mem_valid <= 1'b0;
            end
        end
    end

    initial begin
        #60000;
        $display("Timeout: simulation did not finish within 60 us");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_insn(input logic [icache_pkg::INSN_WIDTH-1:0] got,
                              input logic [icache_pkg::INSN_WIDTH-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, msg, got, exp);
            err_count++;
        end
    endtask

    task automatic check_addr(input icache_pkg::ic_addr_t got, input icache_pkg::ic_addr_t exp,
                              input string msg);
        if (got.raw !== exp.raw) begin
            $display("ERROR %0t: %s got %h expected %h", $time, msg, got.raw, exp.raw);
            err_count++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %b expected %b", $time, msg, got, exp);
            err_count++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (o_busy && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (o_busy) begin
            $display("Refill never finished at %0t", $time);
            err_count++;
        end
    endtask

    // Issue one fetch once idle and return its result
    task automatic fetch_once(input logic [31:0] addr, output logic hit,
                              output logic [31:0] insn);
        int  n;
        logic got;
        wait_idle();
        @(posedge clk);
        i_fetch_en       <= 1'b1;
        i_fetch_addr.raw <= addr;
        @(posedge clk);
        i_fetch_en <= 1'b0;
        got = 1'b0;
        n   = 0;
        hit = 1'b0;
        insn = '0;
        while (!got && n < 8) begin
            @(negedge clk);
            if (o_fetch_valid) begin
                got  = 1'b1;
                hit  = o_fetch_hit;
                insn = o_fetch_insn;
            end
            n++;
        end
        if (!got) begin
            $display("No fetch result for address %h at %0t", addr, $time);
            err_count++;
        end
    endtask

    task automatic pulse_inval();
        @(posedge clk);
        i_inval <= 1'b1;
        @(posedge clk);
        i_inval <= 1'b0;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic reset_values();
        int          e;
        logic        hit;
        logic [31:0] insn;
        e = err_count;
        @(negedge clk);
        check_flag(o_fetch_valid, 1'b0, "valid after reset");
        check_flag(o_busy, 1'b0, "busy after reset");
        check_flag(o_mem_req, 1'b0, "mem req after reset");
        fetch_once(32'h0000_0100, hit, insn);
        check_flag(hit, 1'b0, "hit on empty cache");
        wait_idle();
        finish_test("reset", e);
    endtask

    task automatic cold_miss();
        int                   e;
        int                   reqs;
        logic                 hit;
        logic [31:0]          insn;
        icache_pkg::ic_addr_t exp;
        e = err_count;
        reqs = req_count;
        fetch_once(32'h0000_2234, hit, insn);
        check_flag(hit, 1'b0, "cold fetch hit");
        @(negedge clk);
        check_flag(o_busy, 1'b1, "busy after miss");
        wait_idle();
        exp.raw = 32'h0000_2230;
        check_flag(req_count == reqs + 1, 1'b1, "one request per miss");
        check_addr(last_req_addr, exp, "request address");
        finish_test("cold_miss", e);
    endtask

    task automatic fill_then_hit();
        int          e;
        int          reqs;
        logic        hit;
        logic [31:0] insn;
        e = err_count;
        reqs = req_count;
        for (int w = 0; w < 4; w++) begin
            fetch_once(32'h0000_2230 + 32'(w * 4), hit, insn);
            check_flag(hit, 1'b1, "hit after fill");
            check_insn(insn, mem_word(32'h0000_2230 + 32'(w * 4)), "filled word");
        end
        check_flag(req_count == reqs, 1'b1, "no request on hits");
        finish_test("fill_hit", e);
    endtask

    task automatic tag_conflict();
        int          e;
        logic        hit;
        logic [31:0] insn;
        e = err_count;
        fetch_once(32'h0000_3230, hit, insn);
        check_flag(hit, 1'b0, "conflicting tag hit");
        fetch_once(32'h0000_3238, hit, insn);
        check_flag(hit, 1'b1, "conflicting line after refill");
        check_insn(insn, mem_word(32'h0000_3238), "conflicting line word");
        fetch_once(32'h0000_2230, hit, insn);
        check_flag(hit, 1'b0, "evicted line hit");
        fetch_once(32'h0000_0104, hit, insn);
        check_flag(hit, 1'b1, "other index lost");
        check_insn(insn, mem_word(32'h0000_0104), "other index word");
        wait_idle();
        finish_test("conflict", e);
    endtask

    task automatic invalidate_lines();
        int          e;
        logic        hit;
        logic [31:0] insn;
        e = err_count;
        fetch_once(32'h0000_0100, hit, insn);
        check_flag(hit, 1'b1, "hit before invalidate");
        pulse_inval();
        fetch_once(32'h0000_0100, hit, insn);
        check_flag(hit, 1'b0, "hit after invalidate");
        fetch_once(32'h0000_2230, hit, insn);
        check_flag(hit, 1'b0, "invalidated line hit");
        // Line 0 is valid again and line 3 is being filled
        @(posedge clk);
        pulse_inval();
        wait_idle();
        fetch_once(32'h0000_0100, hit, insn);
        check_flag(hit, 1'b1, "invalidate while busy cleared a line");
        fetch_once(32'h0000_2234, hit, insn);
        check_flag(hit, 1'b1, "invalidate while busy lost the filled line");
        finish_test("inval", e);
    endtask

    task automatic back_to_back();
        int                                e;
        int                                hits;
        logic                              busy_prev;
        logic                              exp_hit;
        logic [31:0]                       addr;
        logic [31:0]                       lines[3];
        logic                              rec_valid[icache_pkg::NUM_LINES];
        logic [icache_pkg::TAG_WIDTH-1:0]  rec_tag[icache_pkg::NUM_LINES];
        logic [31:0]                       pend_addr[$];
        logic                              pend_hit[$];
        logic [31:0]                       retry[$];
        icache_pkg::ic_addr_t              a;
        e = err_count;
        hits = 0;
        lines = '{32'h0000_4000, 32'h0000_5000, 32'h0000_4020};
        wait_idle();
        pulse_inval();
        foreach (rec_valid[i]) rec_valid[i] = 1'b0;
        busy_prev = 1'b0;
        for (int cyc = 0; cyc < 200; cyc++) begin
            @(negedge clk);
            if (busy_prev && !o_busy) begin
                rec_valid[last_req_addr.f.index] = 1'b1;
                rec_tag[last_req_addr.f.index]   = last_req_addr.f.tag;
            end
            if (i_fetch_en) begin
                a = i_fetch_addr;
                if (o_busy) begin
                    retry.push_back(a.raw);
                end else begin
                    pend_addr.push_back(a.raw);
                    pend_hit.push_back(rec_valid[a.f.index] && rec_tag[a.f.index] == a.f.tag);
                end
            end
            if (o_fetch_valid) begin
                addr    = pend_addr.pop_front();
                exp_hit = pend_hit.pop_front();
                check_flag(o_fetch_hit, exp_hit, "back-to-back hit");
                if (o_fetch_hit) begin
                    check_insn(o_fetch_insn, mem_word(addr), "back-to-back word");
                    hits++;
                end else begin
                    retry.push_back(addr);
                end
            end
            busy_prev = o_busy;
            @(posedge clk);
            if (cyc < 190) begin
                if (retry.size() > 0) begin
                    addr = retry.pop_front();
                end else begin
                    addr = lines[($random(seed) & 32'h7fff_ffff) % 3] + 32'(($random(seed) & 3) * 4);
                end
                i_fetch_en       <= 1'b1;
                i_fetch_addr.raw <= addr;
            end else begin
                i_fetch_en <= 1'b0;
            end
        end
        check_flag(hits > 0, 1'b1, "back-to-back saw hits");
        finish_test("back_to_back", e);
    endtask

    initial begin
        i_fetch_en       = 1'b0;
        i_fetch_addr.raw = '0;
        i_inval          = 1'b0;
        i_mem_valid      = 1'b0;
        i_mem_data       = '0;
        err_count        = 0;
        req_count        = 0;
        last_req_addr    = '0;
        @(posedge i_rst_n);
        reset_values();
        cold_miss();
        fill_then_hit();
        tag_conflict();
        invalidate_lines();
        back_to_back();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                                clk,
    input  logic                                i_rst_n,

    input  logic                                i_fetch_en,
    input  icache_pkg::ic_addr_t                i_fetch_addr,
    input  logic                                i_inval,
    input  logic                                i_mem_valid,
    input  logic [icache_pkg::INSN_WIDTH-1:0]   i_mem_data,

    output logic                                o_fetch_valid,
    output logic                                o_fetch_hit,
    output logic [icache_pkg::INSN_WIDTH-1:0]   o_fetch_insn,
    output logic                                o_busy,
    output logic                                o_mem_req,
    output icache_pkg::ic_addr_t                o_mem_addr
);

    logic                                rd_en;
    logic [icache_pkg::INDEX_WIDTH-1:0]  rd_index;
    logic                                rd_valid;
    logic [icache_pkg::TAG_WIDTH-1:0]    rd_tag;
    logic [icache_pkg::LINE_WIDTH-1:0]   rd_line;
    logic                                miss;
    icache_pkg::ic_addr_t                miss_addr;
    logic                                line_done;
    logic [icache_pkg::LINE_WIDTH-1:0]   line_data;
    logic                                fill_en;
    logic [icache_pkg::INDEX_WIDTH-1:0]  fill_index;
    logic [icache_pkg::TAG_WIDTH-1:0]    fill_tag;
    logic                                clr_valid;

    icache icache_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_fetch_en(i_fetch_en), .i_fetch_addr(i_fetch_addr), .i_busy(o_busy),
        .i_rd_valid(rd_valid), .i_rd_tag(rd_tag), .i_rd_line(rd_line),
        .o_rd_en(rd_en), .o_rd_index(rd_index),
        .o_fetch_valid(o_fetch_valid), .o_fetch_hit(o_fetch_hit),
        .o_fetch_insn(o_fetch_insn), .o_miss(miss), .o_miss_addr(miss_addr)
    );

    icache_ram icache_ram_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_rd_en(rd_en), .i_rd_index(rd_index),
        .i_wr_en(fill_en), .i_wr_index(fill_index), .i_wr_tag(fill_tag),
        .i_wr_line(line_data), .i_clr_valid(clr_valid),
        .o_rd_valid(rd_valid), .o_rd_tag(rd_tag), .o_rd_line(rd_line)
    );

    icache_fill_buffer icache_fill_buffer_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_start(o_mem_req), .i_mem_valid(i_mem_valid), .i_mem_data(i_mem_data),
        .o_line_done(line_done), .o_line_data(line_data)
    );

    icache_refill_fsm icache_refill_fsm_inst (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_miss(miss), .i_miss_addr(miss_addr), .i_line_done(line_done),
        .i_inval(i_inval),
        .o_busy(o_busy), .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr),
        .o_fill_en(fill_en), .o_fill_index(fill_index), .o_fill_tag(fill_tag),
        .o_clr_valid(clr_valid)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module icache_tb -o icache_sim; then
    echo "Build failed"
    exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi

if ! grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

// ==== tb.f ====
icache_pkg.sv
icache_ram.sv
icache.sv
icache_fill_buffer.sv
icache_refill_fsm.sv
icache_top.sv
icache_checker.sv
tb_clk_gen.sv
icache_tb.sv

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic o_rst_n
);

    // 20 ns period with reset low for the first two rising edges
    initial begin
        clk     = 1'b0;
        o_rst_n = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (2) @(posedge clk);
        o_rst_n <= 1'b1;
    end

endmodule
